// File: files.f
+incdir+src
src/mac_types_pkg.sv
src/arith_pkg.sv
src/wallace_mult8.sv
src/prefix_adder.sv
src/mult16.sv
src/mac_accumulator.sv
src/mac_top.sv
sim/clock_gen.sv
sim/mac_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MAC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module mac_tb -o mac_sim
./obj_dir/mac_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: sim/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and synchronous reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset drops just after the fifth rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: sim/mac_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAC testbench with queue model and assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mac_tb;
    import mac_types_pkg::*;

    // Roughly eight times the cycles the test sequence needs
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk, reset, in_valid, in_ready, in_clear, out_valid, out_ready, in_fire;
    operand_t    a, b;
    acc_t        acc;
    acc_t        model_q[$];
    acc_t        model_sum;
    acc_t        exp_acc = '0;
    int          exp_count = 0;
    int          accept_count = 0;
    int          cycle_count = 0;
    logic        first_accepted = 1'b0;
    logic        lat_mode = 1'b0;
    logic        ready_mode = 1'b0;
    logic [31:0] rng_state = 32'd76833;

    clock_gen clk_gen (.clk(clk), .reset(reset));

    mac_top uut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
        .in_clear(in_clear), .a(a), .b(b), .out_valid(out_valid),
        .out_ready(out_ready), .acc(acc)
    );

    assign in_fire = in_valid && in_ready;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    // Holds the sample on the inputs until the model counts it accepted
    task automatic send_sample(input operand_t x, input operand_t y, input logic clr);
        int target;
        target = accept_count + 1;
        a = x;
        b = y;
        in_clear = clr;
        in_valid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (accept_count != target);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_count != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_alone(input operand_t x, input operand_t y);
        send_sample(x, y, 1'b1);
        wait_drain();
    endtask

    task automatic send_random(input int count);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int i = 0; i < count; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            send_sample(r1[31:16], r2[31:16], (i == 0) || (r2[10:8] == 3'd0));
        end
    endtask

    // Reference model whose outputs move by NBA like DUT state
    always @(posedge clk) begin
        acc_t prod;
        if (reset) begin
            model_q.delete();
            model_sum = '0;
        end else begin
            if (out_valid && out_ready) begin
                if (model_q.size() != 0) begin
                    void'(model_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                prod = acc_t'(a) * acc_t'(b);
                model_sum = in_clear ? prod : model_sum + prod;
                model_q.push_back(model_sum);
                accept_count <= accept_count + 1;
                first_accepted <= 1'b1;
            end
            exp_count <= model_q.size();
            exp_acc <= (model_q.size() != 0) ? model_q[0] : '0;
        end
    end

    // Output sink with random ready under back-pressure
    always @(posedge clk) begin
        logic [31:0] ready_bits;
        #1;
        ready_bits = lcg_next();
        out_ready = ready_mode ? ready_bits[27] : 1'b1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (reset)
        !first_accepted |-> (!out_valid && in_ready))
        else report_error("DUT not idle with in_ready high before the first sample");
    a_lat_two: assert property (@(posedge clk) disable iff (reset)
        (lat_mode && $past(in_fire, 2)) |-> out_valid)
        else report_error("out_valid missing 2 edges after acceptance");
    a_lat_early: assert property (@(posedge clk) disable iff (reset)
        (lat_mode && $past(in_fire, 1)) |-> !out_valid)
        else report_error("out_valid raised 1 edge after acceptance");
    a_beat_expected: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> (exp_count != 0))
        else report_error("output beat with no accepted sample behind it");
    a_beat_value: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> (acc == exp_acc))
        else report_error($sformatf("acc %0h, model expects %0h",
                                    $sampled(acc), $sampled(exp_acc)));
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(acc)))
        else report_error("acc or out_valid changed while stalled");
    a_ready_full: assert property (@(posedge clk) disable iff (reset)
        (exp_count == 2 && !out_ready) |-> !in_ready)
        else report_error("in_ready high with both stages full and stalled");
    a_ready_room: assert property (@(posedge clk) disable iff (reset)
        (exp_count < 2) |-> in_ready)
        else report_error("in_ready low with a free stage");
    a_in_flight: assert property (@(posedge clk) disable iff (reset)
        exp_count <= 2)
        else report_error("more than two samples in flight");

    initial begin
        in_valid = 1'b0;
        in_clear = 1'b0;
        a = '0;
        b = '0;
        out_ready = 1'b1;
        @(negedge reset);
        repeat (4) @(posedge clk);
        #1;
        // Corner and random single products with latency checks
        lat_mode = 1'b1;
        send_alone(16'h0000, 16'h1234);
        send_alone(16'h0001, 16'habcd);
        send_alone(16'hffff, 16'hffff);
        send_alone(16'hffff, 16'h0001);
        for (int i = 0; i < 8; i++) begin
            send_alone(operand_t'(lcg_next() >> 16), operand_t'(lcg_next() >> 16));
        end
        lat_mode = 1'b0;
        send_random(200);
        wait_drain();
        ready_mode = 1'b1;
        send_random(100);
        wait_drain();
        ready_mode = 1'b0;
        // Wrap-around of the 36-bit sum
        send_sample(16'h0000, 16'h0000, 1'b1);
        repeat (20) send_sample(16'hffff, 16'hffff, 1'b0);
        wait_drain();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: src/arith_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Carry codes and bit-level adder functions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package arith_pkg;

    // Upper bit is a|b, lower bit is a&b
    typedef enum logic [1:0] {
        CC_KILL      = 2'b00,
        CC_PROPAGATE = 2'b10,
        CC_GENERATE  = 2'b11
    } carry_code_t;

    // Returns {carry, sum}
    function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
        return {(x & y) | ((x ^ y) & z), x ^ y ^ z};
    endfunction

    // Returns {carry, sum}
    function automatic logic [1:0] half_add(input logic x, input logic y);
        return {x & y, x ^ y};
    endfunction

    // A propagating upper span passes on whatever the lower span decided
    function automatic carry_code_t combine_codes(input carry_code_t hi, input carry_code_t lo);
        return (hi == CC_PROPAGATE) ? lo : hi;
    endfunction

endpackage

// File: src/mac_accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage accumulator with valid/ready control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mac_params.svh"

module mac_accumulator (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    in_clear,
    input  mac_types_pkg::product_t product,
    output logic                    out_valid,
    input  logic                    out_ready,
    output mac_types_pkg::acc_t     acc
);
    import mac_types_pkg::*;

    localparam int EXT = `MAC_ACC_WIDTH - `MAC_PRODUCT_WIDTH;

    logic     s1_valid;
    logic     s1_clear;
    product_t s1_product;
    logic     s2_free;
    logic     s1_advance;
    logic     in_fire;
    acc_t     product_ext;
    acc_t     sum_base;
    acc_t     next_sum;

    // Stage 2 can take a new result once the current beat is gone
    assign s2_free    = !out_valid || out_ready;
    assign s1_advance = s1_valid && s2_free;
    assign in_ready   = !s1_valid || s2_free;
    assign in_fire    = in_valid && in_ready;

    // Stage 1 valid bit
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (in_fire) begin
            s1_product <= product;
            s1_clear   <= in_clear;
        end
    end

    // Clear restarts the sum from this product alone
    assign product_ext = {{EXT{1'b0}}, s1_product};
    assign sum_base    = s1_clear ? '0 : acc;

    prefix_adder #(.WIDTH(`MAC_ACC_WIDTH)) u_acc_add (
        .a(sum_base), .b(product_ext), .cin(1'b0), .sum(next_sum), .cout()
    );

    // Stage 2 holds the running sum, which is also the output beat
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            acc       <= '0;
        end else begin
            if (s2_free) begin
                out_valid <= s1_valid;
            end
            if (s1_advance) begin
                acc <= next_sum;
            end
        end
    end

endmodule

// File: src/mac_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width macros for the MAC datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

// Operand and partial block widths
`define MAC_OPERAND_WIDTH 16
`define MAC_BLOCK_WIDTH   8
// Result widths
`define MAC_PRODUCT_WIDTH 32
`define MAC_ACC_WIDTH     36

`endif

// File: src/mac_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAC top level with the multiplier feeding the accumulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mac_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    in_clear,
    input  mac_types_pkg::operand_t a,
    input  mac_types_pkg::operand_t b,
    output logic                    out_valid,
    input  logic                    out_ready,
    output mac_types_pkg::acc_t     acc
);
    import mac_types_pkg::*;

    // Combinational product of the presented operands
    product_t product;

    mult16 u_mult (
        .a       (a),
        .b       (b),
        .product (product)
    );

    mac_accumulator u_acc (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_clear  (in_clear),
        .product   (product),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .acc       (acc)
    );

endmodule

// File: src/mac_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath word types for the multiplier and
// accumulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mac_params.svh"

package mac_types_pkg;

    // Full input operand
    typedef logic [`MAC_OPERAND_WIDTH-1:0] operand_t;

    // One half of an operand and its 8x8 product
    typedef logic [`MAC_BLOCK_WIDTH-1:0] block_t;
    typedef logic [2*`MAC_BLOCK_WIDTH-1:0] block_product_t;

    // 16x16 product
    typedef logic [`MAC_PRODUCT_WIDTH-1:0] product_t;

    // Running sum that wraps modulo 2**36
    typedef logic [`MAC_ACC_WIDTH-1:0] acc_t;

endpackage

// File: src/mult16.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16x16 multiplier from four 8x8 Wallace blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mac_params.svh"

module mult16 (
    input  mac_types_pkg::operand_t a,
    input  mac_types_pkg::operand_t b,
    output mac_types_pkg::product_t product
);
    import mac_types_pkg::*;

    localparam int BW = `MAC_BLOCK_WIDTH;

    block_t         a_lo, a_hi, b_lo, b_hi;
    block_product_t p_ll, p_lh, p_hl, p_hh;
    block_product_t cross_sum;
    block_product_t mid_sum;
    logic           cross_carry;
    logic           mid_carry;
    block_t         top_byte;

    assign a_lo = a[BW-1:0];
    assign a_hi = a[2*BW-1:BW];
    assign b_lo = b[BW-1:0];
    assign b_hi = b[2*BW-1:BW];

    wallace_mult8 u_mul_ll (.a(a_lo), .b(b_lo), .prod(p_ll));
    wallace_mult8 u_mul_lh (.a(a_lo), .b(b_hi), .prod(p_lh));
    wallace_mult8 u_mul_hl (.a(a_hi), .b(b_lo), .prod(p_hl));
    wallace_mult8 u_mul_hh (.a(a_hi), .b(b_hi), .prod(p_hh));

    // Cross terms share weight 2**8
    prefix_adder #(.WIDTH(2*BW)) u_cross_add (
        .a(p_lh), .b(p_hl), .cin(1'b0), .sum(cross_sum), .cout(cross_carry)
    );

    // High byte of low-low and low byte of high-high fill bits 8..23
    prefix_adder #(.WIDTH(2*BW)) u_mid_add (
        .a(cross_sum), .b({p_hh[BW-1:0], p_ll[2*BW-1:BW]}), .cin(1'b0),
        .sum(mid_sum), .cout(mid_carry)
    );

    // Both carries land on bit 24
    prefix_adder #(.WIDTH(BW)) u_top_add (
        .a(p_hh[2*BW-1:BW]), .b({{(BW-1){1'b0}}, cross_carry}), .cin(mid_carry),
        .sum(top_byte), .cout()
    );

    assign product = {top_byte, mid_sum, p_ll[BW-1:0]};

endmodule

// File: src/prefix_adder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Recursive-doubling prefix adder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module prefix_adder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);
    import arith_pkg::*;

    localparam int LEVELS = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    carry_code_t      base [WIDTH];
    logic [WIDTH-1:0] carry;

    // Bit 0 already knows its carry out, so it is resolved from the start
    assign base[0] = ((a[0] & b[0]) | (a[0] & cin) | (b[0] & cin)) ? CC_GENERATE : CC_KILL;

    for (genvar i = 1; i < WIDTH; i++) begin : code_gen
        assign base[i] = carry_code_t'({a[i] | b[i], a[i] & b[i]});
    end

    // Level l merges each bit with the span 2**l below it
    for (genvar l = 0; l < LEVELS; l++) begin : lvl
        carry_code_t prev [WIDTH];
        carry_code_t code [WIDTH];

        if (l == 0) begin : g_src
            assign prev = base;
        end else begin : g_src
            assign prev = lvl[l-1].code;
        end

        for (genvar i = 0; i < WIDTH; i++) begin : node
            if (i >= (1 << l)) begin : g_merge
                assign code[i] = combine_codes(prev[i], prev[i - (1 << l)]);
            end else begin : g_keep
                assign code[i] = prev[i];
            end
        end
    end

    // Every code is kill or generate by now
    for (genvar i = 0; i < WIDTH; i++) begin : resolve
        assign carry[i] = (lvl[LEVELS-1].code[i] == CC_GENERATE);
    end

    assign sum[0] = a[0] ^ b[0] ^ cin;
    for (genvar i = 1; i < WIDTH; i++) begin : sum_bit
        assign sum[i] = a[i] ^ b[i] ^ carry[i-1];
    end
    assign cout = carry[WIDTH-1];

endmodule

// File: src/wallace_mult8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8x8 Wallace-tree multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mac_params.svh"

module wallace_mult8 (
    input  mac_types_pkg::block_t         a,
    input  mac_types_pkg::block_t         b,
    output mac_types_pkg::block_product_t prod
);
    import arith_pkg::*;

    localparam int NR = `MAC_BLOCK_WIDTH;
    localparam int PW = 2 * `MAC_BLOCK_WIDTH;

    // Rows left after a number of 3:2 compression levels
    function automatic int rows_after(input int level);
        int n;
        n = NR;
        for (int k = 0; k < level; k++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    function automatic int tree_depth();
        int d;
        d = 0;
        while (rows_after(d) > 2) begin
            d++;
        end
        return d;
    endfunction

    localparam int DEPTH = tree_depth();

    logic [PW-1:0] pp [NR];
    logic [PW-1:0] row_x;
    logic [PW-1:0] row_y;

    // AND partial products, each row shifted to its weight
    for (genvar j = 0; j < NR; j++) begin : pp_row
        assign pp[j] = PW'(a & {NR{b[j]}}) << j;
    end

    for (genvar lv = 0; lv < DEPTH; lv++) begin : lvl
        localparam int NIN  = rows_after(lv);
        localparam int NGRP = NIN / 3;
        localparam int NOUT = rows_after(lv + 1);

        logic [PW-1:0] cur [NIN];
        logic [PW-1:0] nxt [NOUT];

        if (lv == 0) begin : g_src
            assign cur = pp;
        end else begin : g_src
            assign cur = lvl[lv-1].nxt;
        end

        // Each group of three rows becomes a sum row and a carry row
        for (genvar g = 0; g < NGRP; g++) begin : grp
            logic [PW-1:0] s;
            logic [PW-1:0] c;
            for (genvar i = 0; i < PW; i++) begin : col
                assign {c[i], s[i]} = full_add(cur[3*g][i], cur[3*g+1][i], cur[3*g+2][i]);
            end
            assign nxt[2*g]   = s;
            // Top carry is always zero since the product fits in PW bits
            assign nxt[2*g+1] = {c[PW-2:0], 1'b0};
        end

        // Leftover rows wait for the next level
        for (genvar r = 3 * NGRP; r < NIN; r++) begin : pass
            assign nxt[2*NGRP + r - 3*NGRP] = cur[r];
        end
    end

    assign row_x = lvl[DEPTH-1].nxt[0];
    assign row_y = lvl[DEPTH-1].nxt[1];

    // Final carry-propagate step over the last two rows
    always_comb begin
        logic carry;
        {carry, prod[0]} = half_add(row_x[0], row_y[0]);
        for (int i = 1; i < PW; i++) begin
            {carry, prod[i]} = full_add(row_x[i], row_y[i], carry);
        end
    end

endmodule
